// File: verilog/knn_cfg_pkg.sv
package knn_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // sorting network shape
  //////////////////////////////////////////////////////////////////////

  localparam int num_lanes = 8;  // points per beat.
  localparam int num_best  = 4;  // neighbours kept per query.

  // lane number sits in the low bits of an index.
  localparam int lane_w = $clog2(num_lanes);

  // register stages from sorter input to sorter output.
  localparam int sort_depth = 6;

  //////////////////////////////////////////////////////////////////////
  // point index
  //////////////////////////////////////////////////////////////////////

  localparam int idx_w  = 15;              // up to 32768 points per query.
  localparam int beat_w = idx_w - lane_w;  // beat number above the lane.

  typedef logic [idx_w-1:0] idx_t;

endpackage

// File: verilog/knn_point_pkg.sv
package knn_point_pkg;

  //////////////////////////////////////////////////////////////////////
  // point format
  //////////////////////////////////////////////////////////////////////

  // unsigned coordinates, same format for x and y.
  localparam int coord_w = 12;

  typedef logic [coord_w-1:0] coord_t;

  //////////////////////////////////////////////////////////////////////
  // squared euclidean distance
  //////////////////////////////////////////////////////////////////////

  // one squared difference needs 2*coord_w bits.
  // the sum of the x and y terms needs one more.
  localparam int dist_w = 2 * coord_w + 1;

  typedef logic [dist_w-1:0] dist_t;

endpackage

// File: verilog/knn_dist_lanes.sv
`timescale 1ns/1ps

module knn_dist_lanes
  import knn_cfg_pkg::*;
  import knn_point_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   query_load,
  input  coord_t query_x,
  input  coord_t query_y,
  input  logic   ref_valid,
  input  logic   ref_first,
  input  logic   ref_last,
  input  coord_t ref_x [num_lanes],
  input  coord_t ref_y [num_lanes],
  output logic   pt_valid,
  output logic   pt_first,
  output logic   pt_last,
  output dist_t  pt_dist [num_lanes],
  output idx_t   pt_idx [num_lanes]
);

  coord_t            query_x_q;
  coord_t            query_y_q;
  logic [beat_w-1:0] beat_cnt;
  logic [beat_w-1:0] beat_idx;

  logic              s1_valid;
  logic              s1_first;
  logic              s1_last;
  coord_t            s1_dx [num_lanes];
  coord_t            s1_dy [num_lanes];
  logic [beat_w-1:0] s1_beat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      query_x_q <= '0;
      query_y_q <= '0;
    end else if (query_load) begin
      query_x_q <= query_x;
      query_y_q <= query_y;
    end
  end

  // first beat of a query always counts as beat zero.
  assign beat_idx = ref_first ? '0 : beat_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (ref_valid) begin
      beat_cnt <= beat_idx + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1, absolute differences
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_first <= 1'b0;
      s1_last  <= 1'b0;
      s1_beat  <= '0;
      for (int k = 0; k < num_lanes; k++) begin
        s1_dx[k] <= '0;
        s1_dy[k] <= '0;
      end
    end else begin
      s1_valid <= ref_valid;
      s1_first <= ref_first;
      s1_last  <= ref_last;
      if (ref_valid) begin
        s1_beat <= beat_idx;
        for (int k = 0; k < num_lanes; k++) begin
          s1_dx[k] <= (ref_x[k] > query_x_q) ? ref_x[k] - query_x_q : query_x_q - ref_x[k];
          s1_dy[k] <= (ref_y[k] > query_y_q) ? ref_y[k] - query_y_q : query_y_q - ref_y[k];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, sum of squares
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pt_valid <= 1'b0;
      pt_first <= 1'b0;
      pt_last  <= 1'b0;
      for (int k = 0; k < num_lanes; k++) begin
        pt_dist[k] <= '0;
        pt_idx[k]  <= '0;
      end
    end else begin
      pt_valid <= s1_valid;
      pt_first <= s1_first;
      pt_last  <= s1_last;
      if (s1_valid) begin
        for (int k = 0; k < num_lanes; k++) begin
          pt_dist[k] <= dist_t'(s1_dx[k]) * dist_t'(s1_dx[k])
                      + dist_t'(s1_dy[k]) * dist_t'(s1_dy[k]);
          pt_idx[k]  <= {s1_beat, lane_w'(k)};  // beat * 8 + lane.
        end
      end
    end
  end

endmodule

// File: verilog/bitonic_sorter.sv
`timescale 1ns/1ps

module bitonic_sorter
  import knn_cfg_pkg::*;
  import knn_point_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  valid_in,
  input  logic  query_first_in,
  input  logic  query_last_in,
  input  dist_t data_in [num_lanes],
  input  idx_t  idx_in [num_lanes],
  output logic  valid_out,
  output logic  query_first_out,
  output logic  query_last_out,
  output dist_t data_out [num_best],
  output idx_t  idx_out [num_best]
);

  logic [sort_depth-1:0] first_sr;
  logic [sort_depth-1:0] last_sr;

  logic  s0_valid;
  dist_t s0_dist [num_lanes];
  idx_t  s0_idx [num_lanes];
  logic  s1_valid;
  dist_t s1_dist [num_lanes];
  idx_t  s1_idx [num_lanes];
  logic  s2_valid;
  dist_t s2_dist [num_lanes];
  idx_t  s2_idx [num_lanes];
  logic  s3_valid;
  dist_t s3_dist [num_best];
  idx_t  s3_idx [num_best];
  logic  s4_valid;
  dist_t s4_dist [num_best];
  idx_t  s4_idx [num_best];
  logic  s5_valid;
  dist_t s5_dist [num_best];
  idx_t  s5_idx [num_best];

  // pair needs exchanging for the wanted direction.
  function automatic logic exch(dist_t lo, dist_t hi, logic up);
    return up ? (hi < lo) : (lo < hi);
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_sr <= '0;
      last_sr  <= '0;
    end else begin
      first_sr <= {first_sr[sort_depth-2:0], query_first_in};
      last_sr  <= {last_sr[sort_depth-2:0], query_last_in};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stages 0..2, two sorted groups of four
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s0_valid <= 1'b0;
      for (int k = 0; k < num_lanes; k++) begin
        s0_dist[k] <= '0;
        s0_idx[k]  <= '0;
      end
    end else begin
      s0_valid <= valid_in;
      if (valid_in) begin
        for (int k = 0; k < num_lanes; k++) begin
          if (exch(data_in[k & ~1], data_in[k | 1], (k & 2) == 0)) begin  // alternate pairs.
            s0_dist[k] <= data_in[k ^ 1];
            s0_idx[k]  <= idx_in[k ^ 1];
          end else begin
            s0_dist[k] <= data_in[k];
            s0_idx[k]  <= idx_in[k];
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      for (int k = 0; k < num_lanes; k++) begin
        s1_dist[k] <= '0;
        s1_idx[k]  <= '0;
      end
    end else begin
      s1_valid <= s0_valid;
      if (s0_valid) begin
        for (int k = 0; k < num_lanes; k++) begin
          if (exch(s0_dist[k & ~2], s0_dist[k | 2], (k & 4) == 0)) begin
            s1_dist[k] <= s0_dist[k ^ 2];
            s1_idx[k]  <= s0_idx[k ^ 2];
          end else begin
            s1_dist[k] <= s0_dist[k];
            s1_idx[k]  <= s0_idx[k];
          end
        end
      end
    end
  end

  // low group ends ascending, high group descending.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
      for (int k = 0; k < num_lanes; k++) begin
        s2_dist[k] <= '0;
        s2_idx[k]  <= '0;
      end
    end else begin
      s2_valid <= s1_valid;
      if (s1_valid) begin
        for (int k = 0; k < num_lanes; k++) begin
          if (exch(s1_dist[k & ~1], s1_dist[k | 1], (k & 4) == 0)) begin
            s2_dist[k] <= s1_dist[k ^ 1];
            s2_idx[k]  <= s1_idx[k ^ 1];
          end else begin
            s2_dist[k] <= s1_dist[k];
            s2_idx[k]  <= s1_idx[k];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 3, keep the lower half
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s3_valid <= 1'b0;
      for (int k = 0; k < num_best; k++) begin
        s3_dist[k] <= '0;
        s3_idx[k]  <= '0;
      end
    end else begin
      s3_valid <= s2_valid;
      if (s2_valid) begin
        for (int k = 0; k < num_best; k++) begin
          if (s2_dist[k + num_best] < s2_dist[k]) begin
            s3_dist[k] <= s2_dist[k + num_best];
            s3_idx[k]  <= s2_idx[k + num_best];
          end else begin
            s3_dist[k] <= s2_dist[k];
            s3_idx[k]  <= s2_idx[k];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stages 4..5, bitonic clean-up of four
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s4_valid <= 1'b0;
      for (int k = 0; k < num_best; k++) begin
        s4_dist[k] <= '0;
        s4_idx[k]  <= '0;
      end
    end else begin
      s4_valid <= s3_valid;
      if (s3_valid) begin
        for (int k = 0; k < num_best; k++) begin
          if (exch(s3_dist[k & ~2], s3_dist[k | 2], 1'b1)) begin
            s4_dist[k] <= s3_dist[k ^ 2];
            s4_idx[k]  <= s3_idx[k ^ 2];
          end else begin
            s4_dist[k] <= s3_dist[k];
            s4_idx[k]  <= s3_idx[k];
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s5_valid <= 1'b0;
      for (int k = 0; k < num_best; k++) begin
        s5_dist[k] <= '0;
        s5_idx[k]  <= '0;
      end
    end else begin
      s5_valid <= s4_valid;
      if (s4_valid) begin
        for (int k = 0; k < num_best; k++) begin
          if (exch(s4_dist[k & ~1], s4_dist[k | 1], 1'b1)) begin
            s5_dist[k] <= s4_dist[k ^ 1];
            s5_idx[k]  <= s4_idx[k ^ 1];
          end else begin
            s5_dist[k] <= s4_dist[k];
            s5_idx[k]  <= s4_idx[k];
          end
        end
      end
    end
  end

  assign valid_out       = s5_valid;
  assign query_first_out = first_sr[sort_depth-1];
  assign query_last_out  = last_sr[sort_depth-1];
  assign data_out        = s5_dist;
  assign idx_out         = s5_idx;

endmodule

// File: verilog/knn_topk_merge.sv
`timescale 1ns/1ps

module knn_topk_merge
  import knn_cfg_pkg::*;
  import knn_point_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  srt_valid,
  input  logic  srt_first,
  input  logic  srt_last,
  input  dist_t srt_dist [num_best],
  input  idx_t  srt_idx [num_best],
  output logic  result_valid,
  output dist_t result_dist [num_best],
  output idx_t  result_idx [num_best]
);

  dist_t best_dist [num_best];  // running best, ascending.
  idx_t  best_idx [num_best];
  dist_t mn_dist [num_best];
  idx_t  mn_idx [num_best];
  dist_t hc_dist [num_best];
  idx_t  hc_idx [num_best];
  dist_t mrg_dist [num_best];
  idx_t  mrg_idx [num_best];

  //////////////////////////////////////////////////////////////////////
  // lowest four of held list and incoming list
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // held list against the reversed incoming list gives a bitonic four.
    for (int k = 0; k < num_best; k++) begin
      if (srt_dist[num_best-1-k] < best_dist[k]) begin
        mn_dist[k] = srt_dist[num_best-1-k];
        mn_idx[k]  = srt_idx[num_best-1-k];
      end else begin
        mn_dist[k] = best_dist[k];
        mn_idx[k]  = best_idx[k];
      end
    end
    for (int k = 0; k < num_best; k++) begin
      if (mn_dist[k | 2] < mn_dist[k & ~2]) begin
        hc_dist[k] = mn_dist[k ^ 2];
        hc_idx[k]  = mn_idx[k ^ 2];
      end else begin
        hc_dist[k] = mn_dist[k];
        hc_idx[k]  = mn_idx[k];
      end
    end
    for (int k = 0; k < num_best; k++) begin
      if (srt_first) begin  // new query, drop the old list.
        mrg_dist[k] = srt_dist[k];
        mrg_idx[k]  = srt_idx[k];
      end else if (hc_dist[k | 1] < hc_dist[k & ~1]) begin
        mrg_dist[k] = hc_dist[k ^ 1];
        mrg_idx[k]  = hc_idx[k ^ 1];
      end else begin
        mrg_dist[k] = hc_dist[k];
        mrg_idx[k]  = hc_idx[k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      for (int k = 0; k < num_best; k++) begin
        best_dist[k]   <= '0;
        best_idx[k]    <= '0;
        result_dist[k] <= '0;
        result_idx[k]  <= '0;
      end
    end else begin
      result_valid <= srt_valid && srt_last;
      if (srt_valid) begin
        best_dist <= mrg_dist;
        best_idx  <= mrg_idx;
      end
      if (srt_valid && srt_last) begin
        result_dist <= mrg_dist;
        result_idx  <= mrg_idx;
      end
    end
  end

endmodule

// File: verilog/knn_top.sv
`timescale 1ns/1ps

module knn_top
  import knn_cfg_pkg::*;
  import knn_point_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   query_load,
  input  coord_t query_x,
  input  coord_t query_y,
  input  logic   ref_valid,
  input  logic   ref_first,
  input  logic   ref_last,
  input  coord_t ref_x [num_lanes],
  input  coord_t ref_y [num_lanes],
  output logic   result_valid,
  output dist_t  result_dist [num_best],
  output idx_t   result_idx [num_best]
);

  // lanes to sorter.
  logic  pt_valid;
  logic  pt_first;
  logic  pt_last;
  dist_t pt_dist [num_lanes];
  idx_t  pt_idx [num_lanes];

  // sorter to merge.
  logic  srt_valid;
  logic  srt_first;
  logic  srt_last;
  dist_t srt_dist [num_best];
  idx_t  srt_idx [num_best];

  knn_dist_lanes u_dist_lanes (
    .clk        (clk),
    .rst_n      (rst_n),
    .query_load (query_load),
    .query_x    (query_x),
    .query_y    (query_y),
    .ref_valid  (ref_valid),
    .ref_first  (ref_first),
    .ref_last   (ref_last),
    .ref_x      (ref_x),
    .ref_y      (ref_y),
    .pt_valid   (pt_valid),
    .pt_first   (pt_first),
    .pt_last    (pt_last),
    .pt_dist    (pt_dist),
    .pt_idx     (pt_idx)
  );

  bitonic_sorter u_sorter (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_in        (pt_valid),
    .query_first_in  (pt_first),
    .query_last_in   (pt_last),
    .data_in         (pt_dist),
    .idx_in          (pt_idx),
    .valid_out       (srt_valid),
    .query_first_out (srt_first),
    .query_last_out  (srt_last),
    .data_out        (srt_dist),
    .idx_out         (srt_idx)
  );

  knn_topk_merge u_merge (
    .clk          (clk),
    .rst_n        (rst_n),
    .srt_valid    (srt_valid),
    .srt_first    (srt_first),
    .srt_last     (srt_last),
    .srt_dist     (srt_dist),
    .srt_idx      (srt_idx),
    .result_valid (result_valid),
    .result_dist  (result_dist),
    .result_idx   (result_idx)
  );

endmodule

// File: test/knn_top_tb.sv
`timescale 1ns/1ps

module knn_top_tb
  import knn_cfg_pkg::*;
  import knn_point_pkg::*;
;

  localparam int clk_period = 4;
  localparam int num_q      = 10;
  localparam int max_beats  = 40;
  localparam int max_pts    = max_beats * num_lanes;
  localparam int latency    = 9;  // last beat in to result strobe.

  logic   clk = 1'b0;
  logic   rst_n;
  logic   query_load;
  coord_t query_x;
  coord_t query_y;
  logic   ref_valid;
  logic   ref_first;
  logic   ref_last;
  coord_t ref_x [num_lanes];
  coord_t ref_y [num_lanes];
  logic   result_valid;
  dist_t  result_dist [num_best];
  idx_t   result_idx [num_best];

  // per query stimulus and expected results.
  coord_t qx [num_q];
  coord_t qy [num_q];
  int     nbeats [num_q];
  int     npts [num_q];
  int     gap [num_q][max_beats];
  coord_t px [num_q][max_pts];
  coord_t py [num_q][max_pts];
  dist_t  pdist [num_q][max_pts];
  dist_t  exp_dist [num_q][num_best];

  int          pend_q [$];
  int          pend_cyc [$];
  int          cyc = 0;
  int          budget_cycles = 0;
  int          val_errs = 0;
  int          proto_errs = 0;
  logic        seen_result = 1'b0;
  logic [31:0] lcg_state = 32'd62574;

  knn_top u_knn_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .query_load   (query_load),
    .query_x      (query_x),
    .query_y      (query_y),
    .ref_valid    (ref_valid),
    .ref_first    (ref_first),
    .ref_last     (ref_last),
    .ref_x        (ref_x),
    .ref_y        (ref_y),
    .result_valid (result_valid),
    .result_dist  (result_dist),
    .result_idx   (result_idx)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // stimulus generation and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic coord_t random_coord();
    logic [31:0] r;
    r = lcg_step();
    return r[31:20];
  endfunction

  function automatic int bounded_int(input int n);
    logic [31:0] r;
    r = lcg_step();
    return int'(r[30:16]) % n;
  endfunction

  function automatic void build_schedule();
    int max_gap;
    for (int q = 0; q < num_q; q++) begin
      case (q)
        0, 1, 2: nbeats[q] = 1;
        3, 4:    nbeats[q] = max_beats;
        default: nbeats[q] = 1 + bounded_int(12);
      endcase
      max_gap   = (q == 4 || q % 2 == 1) ? 3 : 0;  // odd queries get idle cycles.
      npts[q]   = nbeats[q] * num_lanes;
      qx[q]     = random_coord();
      qy[q]     = random_coord();
      for (int b = 0; b < nbeats[q]; b++) begin
        gap[q][b] = (b == 0 || max_gap == 0) ? 0 : bounded_int(max_gap + 1);
        budget_cycles += 1 + gap[q][b];
      end
      for (int i = 0; i < npts[q]; i++) begin
        px[q][i] = random_coord();
        py[q][i] = random_coord();
      end
    end
    // corner cases, zero and full-scale distance.
    qx[1] = '0;
    qy[1] = '0;
    qx[2] = '1;
    qy[2] = '0;
    for (int k = 0; k < num_lanes; k++) begin
      px[1][k] = (k == 3) ? '0 : '1;
      py[1][k] = (k == 3) ? '0 : '1;
      px[2][k] = (k == 1 || k == 6) ? '1 : '0;
      py[2][k] = (k == 1 || k == 6) ? '0 : '1;
    end
    budget_cycles += 20 * num_q;
  endfunction

  // all squared distances of query q, then the four smallest ascending.
  function automatic void nearest_four(input int q);
    bit taken [max_pts];
    int dx;
    int dy;
    int pick;
    for (int i = 0; i < npts[q]; i++) begin
      dx          = int'(px[q][i]) - int'(qx[q]);
      dy          = int'(py[q][i]) - int'(qy[q]);
      pdist[q][i] = dist_t'(dx * dx + dy * dy);
      taken[i]    = 1'b0;
    end
    for (int k = 0; k < num_best; k++) begin
      pick = -1;
      for (int i = 0; i < npts[q]; i++) begin
        if (!taken[i] && (pick < 0 || pdist[q][i] < pdist[q][pick])) begin
          pick = i;
        end
      end
      taken[pick]    = 1'b1;
      exp_dist[q][k] = pdist[q][pick];
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drive helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
    query_load = 1'b0;
    ref_valid  = 1'b0;
    ref_first  = 1'b0;
    ref_last   = 1'b0;
  endtask

  task automatic load_query(input int q);
    query_load = 1'b1;
    query_x    = qx[q];
    query_y    = qy[q];
  endtask

  task automatic put_beat(input int q, input int b);
    ref_valid = 1'b1;
    ref_first = (b == 0);
    ref_last  = (b == nbeats[q] - 1);
    for (int k = 0; k < num_lanes; k++) begin
      ref_x[k] = px[q][b * num_lanes + k];
      ref_y[k] = py[q][b * num_lanes + k];
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    query_load = 1'b0;
    query_x    = '0;
    query_y    = '0;
    ref_valid  = 1'b0;
    ref_first  = 1'b0;
    ref_last   = 1'b0;
    for (int k = 0; k < num_lanes; k++) begin
      ref_x[k] = '0;
      ref_y[k] = '0;
    end
    build_schedule();
    for (int q = 0; q < num_q; q++) begin
      nearest_four(q);
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (4) next_cycle();  // idle, outputs stay at zero.
    next_cycle();
    load_query(0);
    for (int q = 0; q < num_q; q++) begin
      for (int b = 0; b < nbeats[q]; b++) begin
        repeat (gap[q][b]) next_cycle();
        next_cycle();
        put_beat(q, b);
        if (b == nbeats[q] - 1) begin
          pend_q.push_back(q);
          pend_cyc.push_back(cyc + latency);
          if (q + 1 < num_q) begin
            load_query(q + 1);  // next point goes in with this last beat.
          end
        end
      end
    end
    next_cycle();
    for (int i = 0; i < 2 * latency && pend_q.size() > 0; i++) begin
      next_cycle();
    end
    repeat (3) next_cycle();  // room for a stray strobe.
    assert (pend_q.size() == 0) else begin
      proto_errs++;
      $display("%0d queries never returned a result", pend_q.size());
    end
    $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // result checking
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare
    int q;
    int want_cyc;
    if (rst_n && result_valid) begin
      assert (pend_q.size() > 0) else begin
        proto_errs++;
        $display("result_valid pulsed at cycle %0d with no query outstanding", cyc);
      end
      if (pend_q.size() > 0) begin
        q           = pend_q.pop_front();
        want_cyc    = pend_cyc.pop_front();
        seen_result = 1'b1;
        assert (cyc == want_cyc) else begin
          proto_errs++;
          $display("query %0d result came at cycle %0d, expected cycle %0d", q, cyc, want_cyc);
        end
        for (int k = 0; k < num_best; k++) begin
          assert (result_dist[k] === exp_dist[q][k]) else begin
            val_errs++;
            $display("ERR query %0d result_dist[%0d] = %h, exp %h",
                     q, k, result_dist[k], exp_dist[q][k]);
          end
          // any index with the right distance is fine on ties.
          assert (result_idx[k] < npts[q] && pdist[q][result_idx[k]] === result_dist[k]) else begin
            val_errs++;
            $display("ERR query %0d result_idx[%0d] = %h, its distance %h, result_dist %h",
                     q, k, result_idx[k], pdist[q][result_idx[k]], result_dist[k]);
          end
        end
      end
    end else if (rst_n && !seen_result) begin
      for (int k = 0; k < num_best; k++) begin
        assert (result_dist[k] === '0 && result_idx[k] === '0) else begin
          val_errs++;
          $display("ERR result_dist[%0d] = %h, result_idx[%0d] = %h before first result, exp 0",
                   k, result_dist[k], k, result_idx[k]);
        end
      end
    end
  end

  initial begin : watchdog
    wait (budget_cycles > 0);
    #(budget_cycles * clk_period);
    $display("run did not finish within %0d cycles", budget_cycles);
    $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
    $display("Test failed");
    $finish;
  end

endmodule

// File: knn_top.f
verilog/knn_cfg_pkg.sv
verilog/knn_point_pkg.sv
verilog/knn_dist_lanes.sv
verilog/bitonic_sorter.sv
verilog/knn_topk_merge.sv
verilog/knn_top.sv
test/knn_top_tb.sv
